// ==== vlog.f ====
hw/mrr_pkg.sv
hw/mrr_slot_integrator.sv
hw/mrr_pn_search.sv
hw/mrr_loopback_seq.sv
hw/mrr_pulse_modulator.sv
hw/mrr_loopback_top.sv
dv/tb_mrr_loopback.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the loopback testbench with Verilator and run it
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_mrr_loopback -o tb_mrr_loopback \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/tb_mrr_loopback 2>&1 | tee sim.log \
    || { echo "simulation exited with an error"; exit 1; }

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
echo "simulation finished without failure"

// ==== dv/tb_mrr_loopback.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mrr_loopback;

    localparam int NUM_ROWS = 4;
    localparam int MAX_SAMPLES = 4096;
    localparam logic [14:0] PN_CODE = 15'b000100110101111;
    localparam int HIGH_LEVEL = 20000;
    localparam int LOW_LEVEL = 2000;
    localparam int TX_SAMPLES = 32 * 5 * 4;
    localparam int BUSY_TIMEOUT = 400;

    typedef struct packed {
        logic [14:0] recharge_len;
        logic [7:0]  num_payload_bits;
        logic [15:0] wait_step;
        logic [31:0] tx_word;
        logic        tx_disable;
        logic [2:0]  plant_offset;
        logic [3:0]  gap_mask;
    } row_t;

    logic                                     clk = 1'b0;
    logic                                     rst;
    mrr_pkg::sample_t                         smp;
    logic                                     fm_flag;
    logic [mrr_pkg::RECHARGE_WIDTH-1:0]       recharge_len;
    logic [mrr_pkg::NPAYLOAD_WIDTH-1:0]       num_payload_bits;
    logic [mrr_pkg::SLOT_WIDTH-1:0]           wait_step;
    logic [mrr_pkg::TX_WORD_BITS-1:0]         tx_word;
    logic                                     tx_disable;
    mrr_pkg::slot_sym_t                       dec;
    logic                                     tx_pulse;
    mrr_pkg::loop_status_t                    status;

    row_t        rows [NUM_ROWS];
    row_t        cur;
    logic [15:0] samp_mem [MAX_SAMPLES];
    logic [31:0] rng;
    int          n_samples;
    int          n_rx;
    int          n_turn;
    int          n_dec_exp;
    int          slots_per_bit;
    int          model_offset;
    int          acc_idx;
    int          dec_idx;
    int          last_count;
    int          mismatch_count;
    int          problem_count;
    bit          pre_trig;
    bit          first_row;
    bit          pn_prev;
    bit          pn_seen;
    bit          tx_seen;
    bit          timed_out;

    always #20 clk = ~clk;

    mrr_loopback_top DUT (
        .clk                (clk),
        .rst                (rst),
        .i_sample           (smp),
        .i_fm_flag          (fm_flag),
        .i_recharge_len     (recharge_len),
        .i_num_payload_bits (num_payload_bits),
        .i_wait_step        (wait_step),
        .i_tx_word          (tx_word),
        .i_tx_disable       (tx_disable),
        .o_dec              (dec),
        .o_tx_pulse         (tx_pulse),
        .o_status           (status)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // level plus up to 4095 of noise
    function automatic logic [15:0] noisy(input int level);
        rng = xorshift32(rng);
        return level[15:0] + {4'b0000, rng[11:0]};
    endfunction

    // sum of the four samples of a receive slot, counted from the trigger
    function automatic int slot_sum(input int slot_abs);
        int total;
        int i;
        total = 0;
        for (i = 0; i < 4; i++) begin
            total = total + int'(samp_mem[slot_abs * 4 + i]);
        end
        return total;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL %s got 0x%0h expected 0x%0h at %0t ns", name, got, exp, $time);
        mismatch_count++;
    endtask

    task automatic report_problem(input string what);
        $display("error: %s at %0t ns", what, $time);
        problem_count++;
    endtask

    // fills the sample memory for one run and works out the expected offset
    task automatic build_stimulus();
        int  max_bits;
        int  b;
        int  s;
        int  i;
        int  j;
        int  k;
        int  pos;
        int  lvl;
        int  chip;
        int  corr;
        int  best;
        bit  chip_pos;
        max_bits = mrr_pkg::SFO_SEQ_LEN - 1 + int'(cur.num_payload_bits);
        slots_per_bit = int'(cur.recharge_len) + 3;
        pos = 0;
        for (b = 0; b < max_bits; b++) begin
            rng = xorshift32(rng);
            chip_pos = rng[16];
            j = b - int'(cur.plant_offset);
            // a one in the code is sent as a negative chip
            if (j >= 0 && j < 15) begin
                chip_pos = !PN_CODE[14 - j];
            end
            for (s = 0; s < slots_per_bit; s++) begin
                for (i = 0; i < 4; i++) begin
                    lvl = LOW_LEVEL;
                    if ((s == 1 && chip_pos) || (s == 3 && !chip_pos)) begin
                        lvl = HIGH_LEVEL;
                    end
                    samp_mem[pos] = noisy(lvl);
                    pos++;
                end
            end
        end
        best = 0;
        model_offset = 0;
        for (k = 0; k < 8; k++) begin
            corr = 0;
            for (j = 0; j < 15; j++) begin
                chip = slot_sum((k + j) * slots_per_bit + 1)
                       - slot_sum((k + j) * slots_per_bit + 3);
                if (PN_CODE[14 - j]) begin
                    corr = corr - chip;
                end else begin
                    corr = corr + chip;
                end
            end
            if (corr > best) begin
                best = corr;
                model_offset = k;
            end
        end
        n_rx = (model_offset + int'(cur.num_payload_bits)) * slots_per_bit * 4;
        n_turn = int'(cur.wait_step) * 4;
        n_samples = n_rx + n_turn + TX_SAMPLES;
        n_dec_exp = n_rx / 4;
        // turnaround and transmit periods carry only background
        for (pos = n_rx; pos < n_samples; pos++) begin
            samp_mem[pos] = noisy(LOW_LEVEL);
        end
    endtask

    // called at every falling edge, where all DUT outputs are settled
    task automatic observe();
        int   t;
        int   bit_n;
        int   slot_n;
        int   exp_slot;
        int   exp_sum;
        logic exp_last;
        logic exp_pulse;
        if (pre_trig) begin
            if (dec.valid !== 1'b0) report_mismatch("o_dec.valid", dec.valid, 0);
            if (tx_pulse !== 1'b0) report_mismatch("o_tx_pulse", tx_pulse, 0);
            if (status.busy !== 1'b0) report_mismatch("o_status.busy", status.busy, 0);
            if (status.tx_en !== 1'b0) report_mismatch("o_status.tx_en", status.tx_en, 0);
            if (first_row && status.pn_valid !== 1'b0) begin
                report_mismatch("o_status.pn_valid", status.pn_valid, 0);
            end
            if (first_row && status.pn_offset !== '0) begin
                report_mismatch("o_status.pn_offset", status.pn_offset, 0);
            end
        end
        if (dec.valid) begin
            if (dec_idx >= n_dec_exp) begin
                report_problem("decoded symbol outside the receive periods");
            end else begin
                exp_slot = dec_idx % slots_per_bit;
                exp_sum = slot_sum(dec_idx);
                exp_last = (exp_slot == slots_per_bit - 1);
                if (dec.slot !== exp_slot) report_mismatch("o_dec.slot", dec.slot, exp_slot);
                if (dec.sum !== exp_sum) report_mismatch("o_dec.sum", dec.sum, exp_sum);
                if (dec.last !== exp_last) report_mismatch("o_dec.last", dec.last, exp_last);
            end
            dec_idx++;
            if (dec.last) begin
                last_count++;
            end
        end
        if (!pre_trig && status.pn_valid && !pn_prev) begin
            pn_seen = 1'b1;
            if (status.pn_offset !== model_offset) begin
                report_mismatch("o_status.pn_offset", status.pn_offset, model_offset);
            end
        end
        pn_prev = status.pn_valid;
        if (status.tx_en && !tx_seen) begin
            tx_seen = 1'b1;
            if (last_count != model_offset + int'(cur.num_payload_bits)) begin
                report_mismatch("o_dec.last count", last_count,
                                model_offset + int'(cur.num_payload_bits));
            end
        end
        // pulse level every cycle, set by the number of samples accepted so far
        if (!pre_trig) begin
            exp_pulse = 1'b0;
            if (acc_idx >= n_rx + n_turn && acc_idx < n_samples) begin
                t = acc_idx - n_rx - n_turn;
                bit_n = t / 20;
                slot_n = (t / 4) % 5;
                if (!cur.tx_disable) begin
                    exp_pulse = cur.tx_word[bit_n] ? (slot_n == 0) : (slot_n == 2);
                end
            end
            if (tx_pulse !== exp_pulse) report_mismatch("o_tx_pulse", tx_pulse, exp_pulse);
            if (smp.valid && smp.keep) begin
                acc_idx++;
            end
        end
    endtask

    task automatic run_row(input int r);
        int idx;
        int cyc;
        int waited;
        cur = rows[r];
        build_stimulus();
        acc_idx = 0;
        dec_idx = 0;
        last_count = 0;
        pn_seen = 1'b0;
        tx_seen = 1'b0;
        pre_trig = 1'b1;
        // these idle samples arrive before the trigger and are ignored
        for (cyc = 0; cyc < 8; cyc++) begin
            @(posedge clk);
            recharge_len <= cur.recharge_len;
            num_payload_bits <= cur.num_payload_bits;
            wait_step <= cur.wait_step;
            tx_word <= cur.tx_word;
            tx_disable <= cur.tx_disable;
            rng = xorshift32(rng);
            smp.valid <= 1'b1;
            smp.keep <= 1'b1;
            smp.data <= rng[15:0];
            @(negedge clk);
            observe();
        end
        @(posedge clk);
        fm_flag <= 1'b1;
        smp.valid <= 1'b0;
        @(negedge clk);
        observe();
        pre_trig = 1'b0;
        idx = 0;
        cyc = 0;
        while (idx < n_samples) begin
            @(posedge clk);
            fm_flag <= 1'b0;
            if (cur.gap_mask[cyc % 4]) begin
                smp.valid <= 1'b1;
                smp.keep <= 1'b1;
                smp.data <= samp_mem[idx];
                idx++;
            end else begin
                // gaps alternate between no valid and a dropped sample
                rng = xorshift32(rng);
                smp.valid <= cyc[0];
                smp.keep <= ~cyc[0];
                smp.data <= rng[15:0];
            end
            @(negedge clk);
            observe();
            cyc++;
        end
        @(posedge clk);
        smp.valid <= 1'b0;
        @(negedge clk);
        observe();
        waited = 0;
        while (status.busy && waited < BUSY_TIMEOUT) begin
            @(posedge clk);
            @(negedge clk);
            observe();
            waited++;
        end
        if (status.busy) begin
            timed_out = 1'b1;
            report_problem("timeout while waiting for busy to fall after transmit");
        end
        if (!pn_seen) report_problem("pn_valid never rose during the run");
        if (!tx_seen) report_problem("tx_en never rose during the run");
        if (dec_idx != n_dec_exp) report_mismatch("o_dec.valid count", dec_idx, n_dec_exp);
    endtask

    initial begin
        int r;
        // recharge, payload bits, wait, word, disable, planted offset, gap mask
        rows[0] = '{15'd1, 8'd40, 16'd3, 32'hA5C30F96, 1'b0, 3'd3, 4'b1111};
        rows[1] = '{15'd2, 8'd44, 16'd1, 32'h12348CEF, 1'b0, 3'd0, 4'b1011};
        rows[2] = '{15'd3, 8'd40, 16'd7, 32'hFFFF0001, 1'b1, 3'd7, 4'b0111};
        rows[3] = '{15'd5, 8'd42, 16'd2, 32'h80000001, 1'b0, 3'd5, 4'b1101};
        rng = 32'd95;
        rst = 1'b1;
        smp = '0;
        fm_flag = 1'b0;
        recharge_len = '0;
        num_payload_bits = '0;
        wait_step = 16'd1;
        tx_word = '0;
        tx_disable = 1'b0;
        mismatch_count = 0;
        problem_count = 0;
        pre_trig = 1'b1;
        first_row = 1'b1;
        pn_prev = 1'b0;
        timed_out = 1'b0;
        n_dec_exp = 0;
        slots_per_bit = 4;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (r = 0; r < NUM_ROWS && !timed_out; r++) begin
            run_row(r);
            first_row = 1'b0;
        end
        $display("errors: %0d value mismatches, %0d other", mismatch_count, problem_count);
        if (mismatch_count == 0 && problem_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/mrr_loopback_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mrr_loopback_top (
    input  wire                               clk,
    input  wire                               rst,
    input  wire mrr_pkg::sample_t             i_sample,
    input  wire                               i_fm_flag,
    input  wire [mrr_pkg::RECHARGE_WIDTH-1:0] i_recharge_len,
    input  wire [mrr_pkg::NPAYLOAD_WIDTH-1:0] i_num_payload_bits,
    input  wire [mrr_pkg::SLOT_WIDTH-1:0]     i_wait_step,
    input  wire [mrr_pkg::TX_WORD_BITS-1:0]   i_tx_word,
    input  wire                               i_tx_disable,
    output mrr_pkg::slot_sym_t                o_dec,
    output logic                              o_tx_pulse,
    output mrr_pkg::loop_status_t             o_status
);

    mrr_pkg::slot_sym_t             sym;
    mrr_pkg::period_op_e            op;
    logic [mrr_pkg::SLOT_WIDTH-1:0] slot;
    logic                           clear;
    logic                           pn_start;
    logic                           pn_done;
    logic [mrr_pkg::SFO_LOG2-1:0]   pn_offset;
    logic                           tx_active;
    logic                           tx_done;

    mrr_slot_integrator u_integrator (
        .clk            (clk),
        .rst            (rst),
        .i_sample       (i_sample),
        .i_op           (op),
        .i_clear        (clear),
        .i_recharge_len (i_recharge_len),
        .i_wait_step    (i_wait_step),
        .o_sym          (sym),
        .o_slot         (slot)
    );

    mrr_pn_search u_pn_search (
        .clk      (clk),
        .rst      (rst),
        .i_sym    (sym),
        .i_clear  (clear),
        .i_start  (pn_start),
        .o_done   (pn_done),
        .o_offset (pn_offset)
    );

    mrr_loopback_seq u_seq (
        .clk                (clk),
        .rst                (rst),
        .i_fm_flag          (i_fm_flag),
        .i_sym              (sym),
        .i_num_payload_bits (i_num_payload_bits),
        .i_pn_done          (pn_done),
        .i_pn_offset        (pn_offset),
        .i_tx_done          (tx_done),
        .o_op               (op),
        .o_clear            (clear),
        .o_pn_start         (pn_start),
        .o_tx_active        (tx_active),
        .o_status           (o_status)
    );

    mrr_pulse_modulator u_modulator (
        .clk          (clk),
        .rst          (rst),
        .i_sym        (sym),
        .i_slot       (slot),
        .i_tx_active  (tx_active),
        .i_tx_word    (i_tx_word),
        .i_tx_disable (i_tx_disable),
        .o_tx_pulse   (o_tx_pulse),
        .o_done       (tx_done)
    );

    // only receive periods reach the decoded stream
    always_comb begin
        o_dec = sym;
        o_dec.valid = sym.valid & (op == mrr_pkg::OP_RX);
        o_dec.last = sym.last & (op == mrr_pkg::OP_RX);
    end

endmodule

`default_nettype wire

// ==== hw/mrr_pulse_modulator.sv ====
`timescale 1ns/100ps
`default_nettype none

module mrr_pulse_modulator (
    input  wire                             clk,
    input  wire                             rst,
    input  wire mrr_pkg::slot_sym_t         i_sym,
    input  wire [mrr_pkg::SLOT_WIDTH-1:0]   i_slot,
    input  wire                             i_tx_active,
    input  wire [mrr_pkg::TX_WORD_BITS-1:0] i_tx_word,
    input  wire                             i_tx_disable,
    output logic                            o_tx_pulse,
    output logic                            o_done
);

    logic                                     active_q;
    logic                                     period_end;
    logic                                     bit_high;
    logic [$clog2(mrr_pkg::TX_WORD_BITS):0]   bit_ctr;
    logic [$clog2(mrr_pkg::TX_WORD_BITS):0]   bit_idx;

    // the strobe that starts transmit belongs to the turnaround period
    assign period_end = active_q & i_sym.valid & i_sym.last;

    // slot count has already wrapped on the strobe cycle, so look one bit ahead
    assign bit_idx = period_end ? bit_ctr + 1'b1 : bit_ctr;
    assign bit_high = i_tx_word[bit_idx[$clog2(mrr_pkg::TX_WORD_BITS)-1:0]];
    assign o_done = period_end & (bit_ctr == mrr_pkg::TX_WORD_BITS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            active_q <= 1'b0;
            bit_ctr <= '0;
        end else begin
            active_q <= i_tx_active;
            if (!i_tx_active) begin
                bit_ctr <= '0;
            end else if (period_end) begin
                bit_ctr <= bit_idx;
            end
        end
    end

    // pulse in slot 0 for a one, slot 2 for a zero
    always_comb begin
        o_tx_pulse = 1'b0;
        if (i_tx_active && !i_tx_disable && bit_idx < mrr_pkg::TX_WORD_BITS) begin
            o_tx_pulse = bit_high ? (i_slot == 0) : (i_slot == 2);
        end
    end

endmodule

`default_nettype wire

// ==== hw/mrr_loopback_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

module mrr_loopback_seq (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               i_fm_flag,
    input  wire mrr_pkg::slot_sym_t           i_sym,
    input  wire [mrr_pkg::NPAYLOAD_WIDTH-1:0] i_num_payload_bits,
    input  wire                               i_pn_done,
    input  wire [mrr_pkg::SFO_LOG2-1:0]       i_pn_offset,
    input  wire                               i_tx_done,
    output mrr_pkg::period_op_e               o_op,
    output logic                              o_clear,
    output logic                              o_pn_start,
    output logic                              o_tx_active,
    output mrr_pkg::loop_status_t             o_status
);

    mrr_pkg::seq_state_e                state;
    logic                               period_end;
    logic                               pn_valid;
    logic [mrr_pkg::SFO_LOG2-1:0]       pn_offset;
    logic [mrr_pkg::NPAYLOAD_WIDTH:0]   rx_bits;
    logic [mrr_pkg::NPAYLOAD_WIDTH:0]   rx_bits_next;
    logic [mrr_pkg::NPAYLOAD_WIDTH:0]   rx_target;

    assign period_end = i_sym.valid & i_sym.last;
    assign rx_bits_next = rx_bits + 1'b1;
    assign rx_target = {1'b0, i_num_payload_bits}
                       + {{(mrr_pkg::NPAYLOAD_WIDTH + 1 - mrr_pkg::SFO_LOG2){1'b0}}, pn_offset};

    // preamble plus timing window complete
    assign o_pn_start = (state == mrr_pkg::ST_RX_PAYLOAD) & period_end
                        & (rx_bits_next == mrr_pkg::PN_SEQ_LEN + mrr_pkg::SFO_SEQ_LEN);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mrr_pkg::ST_READY;
            rx_bits <= '0;
            pn_valid <= 1'b0;
            pn_offset <= '0;
        end else begin
            if (i_pn_done) begin
                pn_valid <= 1'b1;
                pn_offset <= i_pn_offset;
            end
            case (state)
                mrr_pkg::ST_READY: begin
                    rx_bits <= '0;
                    if (i_fm_flag) begin
                        pn_valid <= 1'b0;
                        state <= mrr_pkg::ST_RX_PAYLOAD;
                    end
                end
                mrr_pkg::ST_RX_PAYLOAD: begin
                    if (period_end) begin
                        rx_bits <= rx_bits_next;
                        if (pn_valid && rx_bits_next == rx_target) begin
                            state <= mrr_pkg::ST_TURNAROUND;
                        end
                    end
                end
                mrr_pkg::ST_TURNAROUND: begin
                    if (period_end) begin
                        state <= mrr_pkg::ST_TX;
                    end
                end
                default: begin
                    if (i_tx_done) begin
                        state <= mrr_pkg::ST_READY;
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (state)
            mrr_pkg::ST_RX_PAYLOAD: o_op = mrr_pkg::OP_RX;
            mrr_pkg::ST_TURNAROUND: o_op = mrr_pkg::OP_TURN;
            mrr_pkg::ST_TX:         o_op = mrr_pkg::OP_TX;
            default:                o_op = mrr_pkg::OP_HOLD;
        endcase
    end

    assign o_clear = (state == mrr_pkg::ST_READY);

    // raised on the turnaround period end so the first pulse covers all of slot 0
    assign o_tx_active = (state == mrr_pkg::ST_TX)
                         | ((state == mrr_pkg::ST_TURNAROUND) & period_end);

    always_comb begin
        o_status.busy = (state != mrr_pkg::ST_READY);
        o_status.tx_en = (state == mrr_pkg::ST_TX);
        o_status.pn_valid = pn_valid;
        o_status.pn_offset = pn_offset;
    end

    // the search has to report before the payload count is reached
    assert property (@(posedge clk) disable iff (rst)
        (state == mrr_pkg::ST_RX_PAYLOAD) && period_end && (rx_bits_next == rx_target)
        |-> pn_valid)
        else $error("payload complete before the search finished");

    assert property (@(posedge clk) disable iff (rst) i_tx_done |-> state == mrr_pkg::ST_TX)
        else $error("modulator done outside transmit");

endmodule

`default_nettype wire

// ==== hw/mrr_pn_search.sv ====
`timescale 1ns/100ps
`default_nettype none

module mrr_pn_search (
    input  wire                               clk,
    input  wire                               rst,
    input  wire mrr_pkg::slot_sym_t           i_sym,
    input  wire                               i_clear,
    input  wire                               i_start,
    output logic                              o_done,
    output logic [mrr_pkg::SFO_LOG2-1:0]      o_offset
);

    mrr_pkg::search_state_e                 state;
    logic signed [mrr_pkg::CHIP_WIDTH-1:0]  chip_mem [2**mrr_pkg::CHIP_ADDR_WIDTH];
    logic [mrr_pkg::SUM_WIDTH-1:0]          zero_sum;
    logic signed [mrr_pkg::CHIP_WIDTH-1:0]  chip_diff;
    logic signed [mrr_pkg::CHIP_WIDTH-1:0]  rd_data;
    logic [mrr_pkg::CHIP_ADDR_WIDTH-1:0]    wr_addr;
    logic [mrr_pkg::CHIP_ADDR_WIDTH-1:0]    rd_addr;
    logic                                   wr_en;
    logic [mrr_pkg::SFO_LOG2-1:0]           cand;
    logic [$clog2(mrr_pkg::PN_SEQ_LEN)-1:0] sub;
    logic                                   acc_en;
    logic [mrr_pkg::PN_SEQ_LEN-1:0]         pn_rot;
    logic signed [mrr_pkg::CORR_WIDTH-1:0]  corr;
    logic signed [mrr_pkg::CORR_WIDTH-1:0]  best_corr;
    logic [mrr_pkg::SFO_LOG2-1:0]           best_cand;
    logic [mrr_pkg::SFO_LOG2-1:0]           winner;

    // chips are only stored before the search has run
    assign wr_en = i_sym.valid & (i_sym.slot == mrr_pkg::ONE_CHIP_SLOT)
                   & (state == mrr_pkg::SRCH_IDLE);
    assign chip_diff = $signed({1'b0, zero_sum}) - $signed({1'b0, i_sym.sum});
    assign rd_addr = {2'b00, cand} + {1'b0, sub};
    assign winner = (corr > best_corr) ? cand : best_cand;

    always_ff @(posedge clk) begin
        if (i_sym.valid && i_sym.slot == mrr_pkg::ZERO_CHIP_SLOT) begin
            zero_sum <= i_sym.sum;
        end
        if (wr_en) begin
            chip_mem[wr_addr] <= chip_diff;
        end
        rd_data <= chip_mem[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            wr_addr <= '0;
        end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mrr_pkg::SRCH_IDLE;
            acc_en <= 1'b0;
            o_done <= 1'b0;
            o_offset <= '0;
        end else begin
            // read data lags the address by one cycle
            acc_en <= (state == mrr_pkg::SRCH_ACCUM);
            o_done <= 1'b0;
            case (state)
                mrr_pkg::SRCH_IDLE: begin
                    if (i_start) begin
                        state <= mrr_pkg::SRCH_ACCUM;
                    end
                end
                mrr_pkg::SRCH_ACCUM: begin
                    if (sub == mrr_pkg::PN_SEQ_LEN - 1) begin
                        state <= mrr_pkg::SRCH_DRAIN;
                    end
                end
                mrr_pkg::SRCH_DRAIN: begin
                    state <= mrr_pkg::SRCH_NEXT;
                end
                mrr_pkg::SRCH_NEXT: begin
                    if (cand == mrr_pkg::SFO_SEQ_LEN - 1) begin
                        state <= mrr_pkg::SRCH_DONE;
                        o_done <= 1'b1;
                        o_offset <= winner;
                    end else begin
                        state <= mrr_pkg::SRCH_ACCUM;
                    end
                end
                mrr_pkg::SRCH_DONE: begin
                    if (i_clear) begin
                        state <= mrr_pkg::SRCH_IDLE;
                    end
                end
                default: state <= mrr_pkg::SRCH_IDLE;
            endcase
        end
    end

    // correlation datapath, loaded when a search starts
    always_ff @(posedge clk) begin
        if (state == mrr_pkg::SRCH_IDLE && i_start) begin
            cand <= '0;
            sub <= '0;
            corr <= '0;
            best_corr <= '0;
            best_cand <= '0;
            pn_rot <= mrr_pkg::PN_SEQ;
        end else begin
            if (state == mrr_pkg::SRCH_ACCUM) begin
                sub <= sub + 1'b1;
            end
            // the code is read msb first and a full rotation restores it for the next offset
            if (acc_en) begin
                pn_rot <= {pn_rot[mrr_pkg::PN_SEQ_LEN-2:0], pn_rot[mrr_pkg::PN_SEQ_LEN-1]};
                corr <= pn_rot[mrr_pkg::PN_SEQ_LEN-1] ? corr - rd_data : corr + rd_data;
            end
            // best_corr starts at zero, so only positive sums win
            if (state == mrr_pkg::SRCH_NEXT) begin
                corr <= '0;
                sub <= '0;
                cand <= cand + 1'b1;
                if (corr > best_corr) begin
                    best_corr <= corr;
                    best_cand <= cand;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) i_start |-> state == mrr_pkg::SRCH_IDLE)
        else $error("search started while busy");

    // the sequencer must start the search once all preamble chips are in
    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> wr_addr < (mrr_pkg::PN_SEQ_LEN + mrr_pkg::SFO_SEQ_LEN))
        else $error("chip write past preamble window");

endmodule

`default_nettype wire

// ==== hw/mrr_slot_integrator.sv ====
`timescale 1ns/100ps
`default_nettype none

module mrr_slot_integrator (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire mrr_pkg::sample_t               i_sample,
    input  wire mrr_pkg::period_op_e            i_op,
    input  wire                                 i_clear,
    input  wire [mrr_pkg::RECHARGE_WIDTH-1:0]   i_recharge_len,
    input  wire [mrr_pkg::SLOT_WIDTH-1:0]       i_wait_step,
    output mrr_pkg::slot_sym_t                  o_sym,
    output logic [mrr_pkg::SLOT_WIDTH-1:0]      o_slot
);

    logic                           accept;
    logic                           slot_done;
    logic                           period_end;
    logic [mrr_pkg::OSR_LOG2-1:0]   frac;
    logic [mrr_pkg::SUM_WIDTH-1:0]  accum;
    logic [mrr_pkg::SUM_WIDTH-1:0]  sum_next;
    logic [mrr_pkg::SLOT_WIDTH-1:0] period_len;

    // nothing is counted while the sequencer holds
    assign accept = i_sample.valid & i_sample.keep & (i_op != mrr_pkg::OP_HOLD);
    assign slot_done = accept & (frac == '1);
    assign sum_next = accum + {{mrr_pkg::OSR_LOG2{1'b0}}, i_sample.data};

    always_comb begin
        case (i_op)
            mrr_pkg::OP_RX:   period_len = {1'b0, i_recharge_len} + 16'd3;
            mrr_pkg::OP_TURN: period_len = i_wait_step;
            mrr_pkg::OP_TX:   period_len = mrr_pkg::TX_PERIOD_SLOTS[mrr_pkg::SLOT_WIDTH-1:0];
            default:          period_len = '0;
        endcase
    end

    assign period_end = (o_slot == period_len - 1'b1);

    // fractional part counts samples within the slot, o_slot counts slots
    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            frac <= '0;
            o_slot <= '0;
            accum <= '0;
        end else if (accept) begin
            frac <= frac + 1'b1;
            if (slot_done) begin
                accum <= '0;
                o_slot <= period_end ? '0 : o_slot + 1'b1;
            end else begin
                accum <= sum_next;
            end
        end
    end

    // one soft symbol per slot, a cycle after its fourth sample
    always_ff @(posedge clk) begin
        if (slot_done) begin
            o_sym.slot <= o_slot;
            o_sym.sum <= sum_next;
        end
        if (rst) begin
            o_sym.valid <= 1'b0;
            o_sym.last <= 1'b0;
        end else begin
            o_sym.valid <= slot_done;
            o_sym.last <= slot_done & period_end;
        end
    end

    // period length may change with the opcode, the slot count must already be inside it
    assert property (@(posedge clk) disable iff (rst || i_op == mrr_pkg::OP_HOLD)
        o_slot < period_len)
        else $error("slot index outside period");

endmodule

`default_nettype wire

// ==== hw/mrr_pkg.sv ====
`default_nettype none

package mrr_pkg;

    // sample stream and slot integration
    localparam int ESAMP_WIDTH = 16;
    localparam int OSR_LOG2 = 2;
    localparam int SLOT_WIDTH = 16;
    localparam int SUM_WIDTH = ESAMP_WIDTH + OSR_LOG2;
    localparam int RECHARGE_WIDTH = 15;
    localparam int NPAYLOAD_WIDTH = 8;

    // preamble code and timing uncertainty
    localparam int PN_SEQ_LEN = 15;
    localparam logic [PN_SEQ_LEN-1:0] PN_SEQ = 15'b000100110101111;
    localparam int SFO_SEQ_LEN = 8;
    localparam int SFO_LOG2 = 3;
    localparam int CHIP_ADDR_WIDTH = 5;
    localparam int CHIP_WIDTH = SUM_WIDTH + 1;
    localparam int CORR_WIDTH = CHIP_WIDTH + 4;

    // return link
    localparam int TX_WORD_BITS = 32;
    localparam int TX_PERIOD_SLOTS = 5;

    // slots of a bit period that hold the zero and one chip energy
    localparam int ZERO_CHIP_SLOT = 1;
    localparam int ONE_CHIP_SLOT = 3;

    typedef struct packed {
        logic                   valid;
        logic                   keep;
        logic [ESAMP_WIDTH-1:0] data;
    } sample_t;

    typedef struct packed {
        logic                  valid;
        logic                  last;
        logic [SLOT_WIDTH-1:0] slot;
        logic [SUM_WIDTH-1:0]  sum;
    } slot_sym_t;

    typedef enum logic [1:0] {
        ST_READY,
        ST_RX_PAYLOAD,
        ST_TURNAROUND,
        ST_TX
    } seq_state_e;

    // selects the period length the integrator wraps at
    typedef enum logic [1:0] {
        OP_HOLD,
        OP_RX,
        OP_TURN,
        OP_TX
    } period_op_e;

    typedef enum logic [2:0] {
        SRCH_IDLE,
        SRCH_ACCUM,
        SRCH_DRAIN,
        SRCH_NEXT,
        SRCH_DONE
    } search_state_e;

    typedef struct packed {
        logic                busy;
        logic                tx_en;
        logic                pn_valid;
        logic [SFO_LOG2-1:0] pn_offset;
    } loop_status_t;

endpackage

`default_nettype wire
